/* verilog/awsf1_stat_pkg.sv */
`default_nettype none

package awsf1_stat_pkg;

   // -------------------------------------------------------------------------
   // Stat bus widths
   // -------------------------------------------------------------------------

   localparam int STAT_ADDR_W = 8;
   localparam int STAT_DATA_W = 32;

   // Independent stat channels to the memory side
   localparam int NUM_STAT_CH = 3;

   // -------------------------------------------------------------------------
   // Stand-in register bank
   // -------------------------------------------------------------------------

   // Words per bank, picked by the low address bits
   localparam int STAT_REG_DEPTH = 16;
   localparam int STAT_IDX_W     = 4;

   // -------------------------------------------------------------------------
   // Bus payloads
   // -------------------------------------------------------------------------

   // Request toward the memory side, one-cycle wr or rd strobe
   typedef struct packed {
      logic                   wr;
      logic                   rd;
      logic [STAT_ADDR_W-1:0] addr;
      logic [STAT_DATA_W-1:0] wdata;
   } stat_req_t;

   // Response back, ack pulses once per request
   typedef struct packed {
      logic                   ack;
      logic [STAT_DATA_W-1:0] rdata;
   } stat_rsp_t;

endpackage

`default_nettype wire

/* verilog/awsf1_sync_pkg.sv */
`default_nettype none

package awsf1_sync_pkg;

   // -------------------------------------------------------------------------
   // Pipe stage counts
   // -------------------------------------------------------------------------

   // Register stages on each stat pipe, request and response alike
   localparam int NUM_CFG_STGS_CL_DDR_ATG = 8;

   // Extra delay before the memory side leaves reset
   localparam int RST_SLC_STAGES = 4;

endpackage

`default_nettype wire

/* verilog/awsf1_rst_sync.sv */
`default_nettype none

module awsf1_rst_sync (
   input  logic clk_main_a0,
   input  logic pipe_rst_n,
   output logic sync_rst_n,
   output logic sh_ddr_sync_rst_n
);

   logic                                      pre_sync_rst_n;
   logic [awsf1_sync_pkg::RST_SLC_STAGES-1:0] slc_rst_q;

   // Two-flop step, drops together with pipe_rst_n
   always_ff @(posedge clk_main_a0)
   begin
      if (!pipe_rst_n)
      begin
         pre_sync_rst_n <= 1'b0;
         sync_rst_n     <= 1'b0;
      end
      else
      begin
         pre_sync_rst_n <= 1'b1;
         sync_rst_n     <= pre_sync_rst_n;
      end
   end

   // Memory-side release trails sync_rst_n by RST_SLC_STAGES cycles
   always_ff @(posedge clk_main_a0)
   begin
      if (!pipe_rst_n)
      begin
         slc_rst_q <= '0;
      end
      else
      begin
         slc_rst_q <= {slc_rst_q[awsf1_sync_pkg::RST_SLC_STAGES-2:0], sync_rst_n};
      end
   end

   assign sh_ddr_sync_rst_n = slc_rst_q[awsf1_sync_pkg::RST_SLC_STAGES-1];

endmodule

`default_nettype wire

/* verilog/awsf1_stat_pipe.sv */
`default_nettype none

module awsf1_stat_pipe #(
   parameter int WIDTH  = 42,
   parameter int STAGES = 8
) (
   input  logic             clk_main_a0,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   logic [WIDTH-1:0] stage_q [STAGES];

   // Shift one stage per cycle, no stall
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            stage_q[i] <= '0;
         end
      end
      else
      begin
         stage_q[0] <= in_bus;
         for (int i = 1; i < STAGES; i++)
         begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   assign out_bus = stage_q[STAGES-1];

endmodule

`default_nettype wire

/* verilog/awsf1_stat_regs.sv */
`default_nettype none

module awsf1_stat_regs (
   input  logic                      clk_main_a0,
   input  logic                      rst_n,
   input  awsf1_stat_pkg::stat_req_t req,
   output awsf1_stat_pkg::stat_rsp_t rsp
);

   logic [awsf1_stat_pkg::STAT_DATA_W-1:0] bank_q [awsf1_stat_pkg::STAT_REG_DEPTH];
   logic [awsf1_stat_pkg::STAT_IDX_W-1:0]  idx;

   // Upper address bits alias onto the same word
   assign idx = req.addr[awsf1_stat_pkg::STAT_IDX_W-1:0];

   // -------------------------------------------------------------------------
   // Word storage
   // -------------------------------------------------------------------------

   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < awsf1_stat_pkg::STAT_REG_DEPTH; i++)
         begin
            bank_q[i] <= '0;
         end
      end
      else if (req.wr)
      begin
         bank_q[idx] <= req.wdata;
      end
   end

   // -------------------------------------------------------------------------
   // Response, one cycle after the request
   // -------------------------------------------------------------------------

   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_n)
      begin
         rsp <= '0;
      end
      else if (req.wr)
      begin
         // Write ack carries no data
         rsp.ack   <= 1'b1;
         rsp.rdata <= '0;
      end
      else if (req.rd)
      begin
         rsp.ack   <= 1'b1;
         rsp.rdata <= bank_q[idx];
      end
      else
      begin
         rsp <= '0;
      end
   end

endmodule

`default_nettype wire

/* verilog/awsf1_stat_top.sv */
`default_nettype none

module awsf1_stat_top (
   input  logic                                                          clk_main_a0,
   input  logic                                                          pipe_rst_n,
   input  awsf1_stat_pkg::stat_req_t [awsf1_stat_pkg::NUM_STAT_CH-1:0] stat_req,
   output awsf1_stat_pkg::stat_rsp_t [awsf1_stat_pkg::NUM_STAT_CH-1:0] stat_rsp
);

   logic sync_rst_n;
   logic sh_ddr_sync_rst_n;

   // -------------------------------------------------------------------------
   // Reset chain
   // -------------------------------------------------------------------------

   awsf1_rst_sync u_rst_sync (
      .clk_main_a0       (clk_main_a0),
      .pipe_rst_n        (pipe_rst_n),
      .sync_rst_n        (sync_rst_n),
      .sh_ddr_sync_rst_n (sh_ddr_sync_rst_n)
   );

   // -------------------------------------------------------------------------
   // Per-channel stat path
   // -------------------------------------------------------------------------

   genvar ch;

   for (ch = 0; ch < awsf1_stat_pkg::NUM_STAT_CH; ch++)
   begin : g_ch
      awsf1_stat_pkg::stat_req_t req_q;
      awsf1_stat_pkg::stat_rsp_t rsp_d;

      // Request toward the bank
      awsf1_stat_pipe #(
         .WIDTH  ($bits(awsf1_stat_pkg::stat_req_t)),
         .STAGES (awsf1_sync_pkg::NUM_CFG_STGS_CL_DDR_ATG)
      ) u_req_pipe (
         .clk_main_a0 (clk_main_a0),
         .rst_n       (sync_rst_n),
         .in_bus      (stat_req[ch]),
         .out_bus     (req_q)
      );

      // Stands in for the memory controller's stat port
      awsf1_stat_regs u_stat_regs (
         .clk_main_a0 (clk_main_a0),
         .rst_n       (sh_ddr_sync_rst_n),
         .req         (req_q),
         .rsp         (rsp_d)
      );

      // Ack and read data back out
      awsf1_stat_pipe #(
         .WIDTH  ($bits(awsf1_stat_pkg::stat_rsp_t)),
         .STAGES (awsf1_sync_pkg::NUM_CFG_STGS_CL_DDR_ATG)
      ) u_rsp_pipe (
         .clk_main_a0 (clk_main_a0),
         .rst_n       (sync_rst_n),
         .in_bus      (rsp_d),
         .out_bus     (stat_rsp[ch])
      );
   end

endmodule

`default_nettype wire

/* bench/tb_awsf1_stat_top.sv */
`default_nettype none

module tb_awsf1_stat_top;

   timeunit 1ns;
   timeprecision 1ps;

   // Request pipe, bank register and response pipe
   localparam int LAT = 2 * awsf1_sync_pkg::NUM_CFG_STGS_CL_DDR_ATG + 1;
   localparam int NCH = awsf1_stat_pkg::NUM_STAT_CH;

   typedef enum logic [1:0] {REQ_IDLE, REQ_WR, REQ_RD} req_kind_t;

   // One expected response, due at a given cycle
   typedef struct packed {
      int                                     due;
      logic [awsf1_stat_pkg::STAT_DATA_W-1:0] rdata;
   } exp_t;

   logic                                clk_main_a0;
   logic                                pipe_rst_n;
   awsf1_stat_pkg::stat_req_t [NCH-1:0] stat_req;
   awsf1_stat_pkg::stat_rsp_t [NCH-1:0] stat_rsp;

   logic [31:0] lfsr_state;
   int          cyc;
   bit          check_en;
   int          mismatch_errors;
   int          timeout_errors;

   // Model banks and in-flight responses per channel
   logic [awsf1_stat_pkg::STAT_DATA_W-1:0] model_bank [NCH][awsf1_stat_pkg::STAT_REG_DEPTH];
   exp_t                                   exp_q [NCH][$];

   awsf1_stat_top u_awsf1_stat_top (
      .clk_main_a0 (clk_main_a0),
      .pipe_rst_n  (pipe_rst_n),
      .stat_req    (stat_req),
      .stat_rsp    (stat_rsp)
   );

   initial
   begin
      clk_main_a0 = 1'b0;
      forever #10 clk_main_a0 = ~clk_main_a0;
   end

   // -------------------------------------------------------------------------
   // Random source, Galois LFSR stepped once per bit
   // -------------------------------------------------------------------------

   function automatic logic [31:0] draw_bits(input int nbits);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < nbits; i++)
      begin
         if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
         else
            lfsr_state = lfsr_state >> 1;
         val = {val[30:0], lfsr_state[0]};
      end
      return val;
   endfunction

   function automatic bit responses_pending();
      bit busy;
      busy = 1'b0;
      for (int c = 0; c < NCH; c++)
      begin
         if (exp_q[c].size() > 0)
            busy = 1'b1;
      end
      return busy;
   endfunction

   // -------------------------------------------------------------------------
   // Response checks against the model
   // -------------------------------------------------------------------------

   task automatic check_outputs();
      awsf1_stat_pkg::stat_rsp_t              got;
      logic                                   exp_ack;
      logic [awsf1_stat_pkg::STAT_DATA_W-1:0] exp_rdata;
      for (int c = 0; c < NCH; c++)
      begin
         got       = stat_rsp[c];
         exp_ack   = 1'b0;
         exp_rdata = '0;
         if (exp_q[c].size() > 0 && exp_q[c][0].due == cyc)
         begin
            exp_ack   = 1'b1;
            exp_rdata = exp_q[c][0].rdata;
            void'(exp_q[c].pop_front());
         end
         assert (got.ack === exp_ack)
         else
         begin
            mismatch_errors++;
            $display("Mismatch: stat_rsp[%0d].ack got 0x%0h, expected 0x%0h (cycle %0d)",
                     c, got.ack, exp_ack, cyc);
         end
         assert (got.rdata === exp_rdata)
         else
         begin
            mismatch_errors++;
            $display("Mismatch: stat_rsp[%0d].rdata got 0x%08h, expected 0x%08h (cycle %0d)",
                     c, got.rdata, exp_rdata, cyc);
         end
      end
   endtask

   // Outputs are stable 2 ns after the edge, inputs change there too
   task automatic advance_clock();
      @(posedge clk_main_a0);
      #2;
      cyc++;
      if (check_en)
         check_outputs();
   endtask

   task automatic next_cycle();
      advance_clock();
      stat_req = '0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   // -------------------------------------------------------------------------
   // Stimulus
   // -------------------------------------------------------------------------

   task automatic issue(input int c, input req_kind_t kind,
                        input logic [awsf1_stat_pkg::STAT_ADDR_W-1:0] addr,
                        input logic [awsf1_stat_pkg::STAT_DATA_W-1:0] data);
      awsf1_stat_pkg::stat_req_t             req;
      exp_t                                  e;
      logic [awsf1_stat_pkg::STAT_IDX_W-1:0] idx;
      req     = '0;
      idx     = addr[awsf1_stat_pkg::STAT_IDX_W-1:0];
      e.due   = cyc + LAT;
      e.rdata = '0;
      if (kind == REQ_WR)
      begin
         req.wr    = 1'b1;
         req.addr  = addr;
         req.wdata = data;
         model_bank[c][idx] = data;
         exp_q[c].push_back(e);
      end
      else if (kind == REQ_RD)
      begin
         req.rd  = 1'b1;
         req.addr = addr;
         e.rdata = model_bank[c][idx];
         exp_q[c].push_back(e);
      end
      stat_req[c] = req;
   endtask

   task automatic random_cycle();
      logic [31:0] kind_bits;
      logic [31:0] addr_bits;
      logic [31:0] data_bits;
      req_kind_t   kind;
      next_cycle();
      for (int c = 0; c < NCH; c++)
      begin
         kind_bits = draw_bits(2);
         addr_bits = draw_bits(awsf1_stat_pkg::STAT_ADDR_W);
         data_bits = draw_bits(awsf1_stat_pkg::STAT_DATA_W);
         case (kind_bits[1:0])
            2'd0:    kind = REQ_IDLE;
            2'd1:    kind = REQ_WR;
            default: kind = REQ_RD;
         endcase
         issue(c, kind, addr_bits[awsf1_stat_pkg::STAT_ADDR_W-1:0], data_bits);
      end
   endtask

   task automatic read_all_words();
      logic [awsf1_stat_pkg::STAT_ADDR_W-1:0] addr;
      for (int w = 0; w < awsf1_stat_pkg::STAT_REG_DEPTH; w++)
      begin
         addr = w[awsf1_stat_pkg::STAT_ADDR_W-1:0];
         next_cycle();
         for (int c = 0; c < NCH; c++)
            issue(c, REQ_RD, addr, '0);
      end
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (responses_pending() && waited < LAT + 8)
      begin
         next_cycle();
         waited++;
      end
      assert (!responses_pending())
      else
      begin
         timeout_errors++;
         $display("Timeout: responses still outstanding after %0d cycles", waited);
      end
   endtask

   // Holds reset for 4 cycles, then clears the model and idles 10 cycles
   task automatic apply_reset();
      check_en   = 1'b0;
      pipe_rst_n = 1'b0;
      stat_req   = '0;
      repeat (4) advance_clock();
      for (int c = 0; c < NCH; c++)
      begin
         exp_q[c].delete();
         for (int w = 0; w < awsf1_stat_pkg::STAT_REG_DEPTH; w++)
            model_bank[c][w] = '0;
      end
      pipe_rst_n = 1'b1;
      check_en   = 1'b1;
      idle_cycles(10);
   endtask

   // -------------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------------

   initial
   begin
      logic [31:0] addr_bits;
      lfsr_state      = 32'h1ae4_1c32;
      cyc             = 0;
      mismatch_errors = 0;
      timeout_errors  = 0;
      check_en        = 1'b0;
      pipe_rst_n      = 1'b0;
      stat_req        = '0;
      apply_reset();

      // Quiet outputs, then every word reads zero
      idle_cycles(5);
      read_all_words();
      drain();

      // Write then read back, per channel
      for (int c = 0; c < NCH; c++)
      begin
         addr_bits = draw_bits(awsf1_stat_pkg::STAT_ADDR_W);
         next_cycle();
         issue(c, REQ_WR, addr_bits[7:0], draw_bits(awsf1_stat_pkg::STAT_DATA_W));
         next_cycle();
         issue(c, REQ_RD, addr_bits[7:0], '0);
      end
      drain();

      // Aliasing above the low index bits
      next_cycle();
      issue(1, REQ_WR, 8'h05, draw_bits(awsf1_stat_pkg::STAT_DATA_W));
      next_cycle();
      issue(1, REQ_WR, 8'h35, draw_bits(awsf1_stat_pkg::STAT_DATA_W));
      next_cycle();
      issue(1, REQ_RD, 8'hf5, '0);
      next_cycle();
      issue(1, REQ_RD, 8'h05, '0);
      drain();

      // Back-to-back random traffic
      repeat (400) random_cycle();
      drain();

      // Channel 0 writes leave channels 1 and 2 alone
      for (int w = 0; w < awsf1_stat_pkg::STAT_REG_DEPTH; w++)
      begin
         next_cycle();
         issue(0, REQ_WR, w[7:0], draw_bits(awsf1_stat_pkg::STAT_DATA_W));
      end
      read_all_words();
      drain();

      // Reset with traffic in flight
      repeat (30) random_cycle();
      apply_reset();
      read_all_words();
      repeat (100) random_cycle();
      drain();
      idle_cycles(5);

      $display("Errors: %0d mismatch, %0d timeout", mismatch_errors, timeout_errors);
      if (mismatch_errors == 0 && timeout_errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* awsf1_stat_top.f */
verilog/awsf1_stat_pkg.sv
verilog/awsf1_sync_pkg.sv
verilog/awsf1_rst_sync.sv
verilog/awsf1_stat_pipe.sv
verilog/awsf1_stat_regs.sv
verilog/awsf1_stat_top.sv
bench/tb_awsf1_stat_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the stat bus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_awsf1_stat_top \
   -f awsf1_stat_top.f

./obj_dir/Vtb_awsf1_stat_top > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0
